// ==== rotate_fx.f ====
verilog/rotate_geom_pkg.sv
verilog/pixel_pkg.sv
verilog/rotate_writer.sv
verilog/frame_store.sv
verilog/rotate_scanout.sv
verilog/rotate_fx.sv
verif/rotate_fx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the rotate_fx testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module rotate_fx_tb -f rotate_fx.f -o rotate_fx_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/rotate_fx_sim; then
	echo "Simulation exited with an error"
	exit 1
fi

exit 0

// ==== verif/rotate_fx_tb.sv ====
//==================================================
// Testbench for the rotating video path
// Frames from the vectors file, every output step
// checked against a rotation model
//==================================================
`default_nettype none

module rotate_fx_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rotate_geom_pkg::*;
	import pixel_pkg::*;

	logic   clk;
	logic   reset;
	logic   pix_ce;
	pix9_t  pix_in;
	logic   hblank;
	logic   vblank;
	logic   rotate_ccw;
	logic   out_ce;
	chan8_t out_r;
	chan8_t out_g;
	chan8_t out_b;
	logic   out_valid;
	logic   out_de;
	logic   out_hblank;
	logic   out_vblank;
	logic   hsync;
	logic   vsync;

	// Three words per frame: direction, seed, gap
	logic [11:0] vectors [0:95];
	int          nvec = 0;
	int          frames_started = 0;
	int          frames_done = 0;
	int          mon_col = 0;
	int          mon_line = 0;
	int          mon_vb = 0;
	bit          mon_in_vb = 1'b1;
	int          de_count = 0;

	rotate_fx DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic pix9_t src_pixel(input int seed, input int r, input int c);
		return pix9_t'((seed + r * SRC_WIDTH + c) & 'h1ff);
	endfunction

	// Three bit field to eight bits, 7 gives 255
	function automatic chan8_t widen(input logic [2:0] f);
		int v;
		v = int'(f) * 73;
		return chan8_t'(v >> 1);
	endfunction

	// Source pixel shown at picture line y, column x
	function automatic pix9_t model_pixel(input int idx, input int y, input int x);
		int seed;
		seed = int'(vectors[3 * idx + 1]);
		if (vectors[3 * idx] == 12'd0) begin
			return src_pixel(seed, SRC_HEIGHT - 1 - x, y);
		end
		return src_pixel(seed, x, SRC_WIDTH - 1 - y);
	endfunction

	task automatic stop_with(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_pixel(input chan8_t got, input chan8_t exp, input string what);
		if (got !== exp) begin
			stop_with($sformatf("mismatch at %0t: %s got %02h expected %02h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			stop_with($sformatf("mismatch at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			stop_with($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, what, got, exp));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	//==================================================
	// Output monitor, one step per out_valid
	//==================================================
	task automatic check_step();
		logic  de_exp;
		pix9_t p;
		string at;
		check_level(out_valid, 1'b1, "out_valid with out_ce held high");
		if (mon_in_vb && (frames_started == 0 || !out_vblank)) begin
			check_count(mon_col, 0, "column at frame start");
			if (frames_started >= nvec) begin
				stop_with("an output frame started with no input frame behind it");
			end
			frames_started++;
			mon_in_vb = 1'b0;
			mon_line  = 0;
			de_count  = 0;
		end
		at = $sformatf(" (frame %0d line %0d col %0d vb %0d)",
			frames_started - 1, mon_line, mon_col, mon_vb);
		de_exp = !mon_in_vb && mon_line >= OUT_MARGIN && mon_line < OUT_MARGIN + SRC_WIDTH
			&& mon_col < SRC_HEIGHT;
		p = de_exp ? model_pixel(frames_started - 1, mon_line - OUT_MARGIN, mon_col) : '0;
		check_level(out_de, de_exp, {"out_de", at});
		check_level(out_hblank, mon_col >= SRC_HEIGHT, {"out_hblank", at});
		check_level(out_vblank, mon_in_vb, {"out_vblank", at});
		check_level(hsync, mon_col >= HS_START && mon_col < HS_END, {"hsync", at});
		check_level(vsync, mon_in_vb && mon_vb >= VS_START && mon_vb < VS_END, {"vsync", at});
		check_pixel(out_r, widen(p[8:6]), {"red", at});
		check_pixel(out_g, widen(p[5:3]), {"green", at});
		check_pixel(out_b, widen(p[2:0]), {"blue", at});
		if (out_de) begin
			de_count++;
		end
		if (mon_col < LINE_LEN - 1) begin
			mon_col++;
		end else begin
			mon_col = 0;
			if (!mon_in_vb && mon_line == OUT_LINES - 1) begin
				check_count(de_count, FRAME_PIXELS, {"pixels with out_de", at});
				mon_in_vb = 1'b1;
				mon_vb    = 0;
			end else if (!mon_in_vb) begin
				mon_line++;
			end else if (mon_vb < VB_LINES) begin
				// Frame counts as seen once its blank lines are out
				if (mon_vb == VB_LINES - 1) begin
					frames_done++;
				end
				mon_vb++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			if (frames_started == 0 && !out_valid) begin
				check_level(out_de, 1'b0, "out_de before the first frame");
				check_level(out_hblank, 1'b0, "out_hblank before the first frame");
				check_level(out_vblank, 1'b0, "out_vblank before the first frame");
				check_level(hsync, 1'b0, "hsync before the first frame");
				check_level(vsync, 1'b0, "vsync before the first frame");
			end else begin
				check_step();
			end
		end
	end

	//==================================================
	// Input frames
	//==================================================
	task automatic send_frame(input int idx);
		int seed;
		int gap;
		int idle;
		seed = int'(vectors[3 * idx + 1]);
		gap  = int'(vectors[3 * idx + 2]);
		vblank = 1'b0;
		for (int r = 0; r < SRC_HEIGHT; r++) begin
			hblank = 1'b0;
			for (int c = 0; c < SRC_WIDTH; c++) begin
				pix_ce = 1'b1;
				pix_in = src_pixel(seed, r, c);
				next_cycle();
				pix_ce = 1'b0;
				idle = (gap == 0) ? int'($urandom_range(3, 0)) : gap;
				repeat (idle) next_cycle();
			end
			// A strobe in blanking must not be written
			hblank = 1'b1;
			pix_ce = 1'b1;
			pix_in = ~src_pixel(seed, r, 0);
			next_cycle();
			pix_ce = 1'b0;
			next_cycle();
		end
		// Direction of the next frame is taken at the vblank rise
		if (idx + 1 < nvec) begin
			rotate_ccw = vectors[3 * idx + 3][0];
		end
		next_cycle();
		vblank = 1'b1;
		hblank = 1'b0;
		next_cycle();
	endtask

	initial begin
		reset      = 1'b1;
		pix_ce     = 1'b0;
		pix_in     = '0;
		hblank     = 1'b0;
		vblank     = 1'b1;
		rotate_ccw = 1'b0;
		out_ce     = 1'b1;
		void'($urandom(66));
		for (int i = 0; i < 96; i++) begin
			vectors[i] = 12'hfff;
		end
		$readmemh("verif/rotate_fx_vectors.txt", vectors);
		while (nvec < 32 && vectors[3 * nvec] != 12'hfff) begin
			nvec++;
		end
		if (nvec == 0) begin
			stop_with("no frames found in verif/rotate_fx_vectors.txt");
		end
		// Writer leaves reset in clockwise mode
		if (vectors[0] != 12'd0) begin
			stop_with("the first frame in the vectors file must be clockwise");
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (2 * LINE_LEN) next_cycle();
		for (int i = 0; i < nvec; i++) begin
			send_frame(i);
			while (frames_done < i + 1) begin
				next_cycle();
			end
		end
		check_count(frames_started, nvec, "output frames at the end");
		$display("Result: PASSED");
		$finish;
	end

	// Two output frames per input frame, plus the quiet start
	initial begin
		int limit;
		@(negedge reset);
		limit = nvec * 2 * LINE_LEN * (OUT_LINES + VB_LINES) + 2 * LINE_LEN;
		repeat (limit) @(posedge clk);
		stop_with($sformatf("timeout after %0d cycles, output frames did not complete", limit));
	end

endmodule

`default_nettype wire

// ==== verif/rotate_fx_vectors.txt ====
// One test frame per line: direction (0 clockwise, 1 counter-clockwise),
// pixel seed in hex, pix_ce gap in idle cycles (0 gives random gaps of 0 to 3)
0 000 1
0 1a5 2
1 000 1
1 0ff 3
0 0ff 1
1 1a5 1
0 1a5 0
1 0ff 0
0 000 0
1 000 0
1 123 2
0 07e 0
1 1fe 1
0 155 3

// ==== verilog/frame_store.sv ====
//==================================================
// Frame store
// Two banks of pixel memory, one write port and
// one registered read port
//==================================================
`default_nettype none

module frame_store #(
	parameter type word_t = pixel_pkg::pix9_t
) (
	input  logic                   clk,
	input  logic                   wr_en,
	input  rotate_geom_pkg::addr_t wr_addr,
	input  word_t                  wr_data,
	input  rotate_geom_pkg::addr_t rd_addr,
	output word_t                  rd_data
);
	import rotate_geom_pkg::*;

	// Bank 0 in the lower half, bank 1 in the upper half
	word_t mem [0:2*FRAME_PIXELS-1];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Writer and scan-out never share a bank
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== verilog/pixel_pkg.sv ====
//==================================================
// Pixel formats
// 3R3G3B input word and its expansion to 8 bits
//==================================================
`default_nettype none

package pixel_pkg;
	// Red in the top field, blue in the bottom one
	typedef logic [8:0] pix9_t;
	typedef logic [7:0] chan8_t;

	function automatic logic [2:0] pix_red(input pix9_t p);
		return p[8:6];
	endfunction

	function automatic logic [2:0] pix_green(input pix9_t p);
		return p[5:3];
	endfunction

	function automatic logic [2:0] pix_blue(input pix9_t p);
		return p[2:0];
	endfunction

	// Repeat the field so full scale maps to 8'hff
	function automatic chan8_t expand3(input logic [2:0] f);
		return {f, f, f[2:1]};
	endfunction
endpackage

`default_nettype wire

// ==== verilog/rotate_fx.sv ====
//==================================================
// Rotating video path
// Writer, double-banked store and portrait scan-out
//==================================================
`default_nettype none

module rotate_fx (
	input  logic              clk,
	input  logic              reset,
	input  logic              pix_ce,
	input  pixel_pkg::pix9_t  pix_in,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              rotate_ccw,
	input  logic              out_ce,
	output pixel_pkg::chan8_t out_r,
	output pixel_pkg::chan8_t out_g,
	output pixel_pkg::chan8_t out_b,
	output logic              out_valid,
	output logic              out_de,
	output logic              out_hblank,
	output logic              out_vblank,
	output logic              hsync,
	output logic              vsync
);
	import rotate_geom_pkg::*;
	import pixel_pkg::*;

	logic  wr_en;
	addr_t wr_addr;
	pix9_t wr_data;
	logic  frame_bank;
	addr_t rd_addr;
	pix9_t rd_data;

	rotate_writer u_writer (
		.clk        (clk),
		.reset      (reset),
		.pix_ce     (pix_ce),
		.pix_in     (pix_in),
		.hblank     (hblank),
		.vblank     (vblank),
		.rotate_ccw (rotate_ccw),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.frame_bank (frame_bank)
	);

	frame_store #(
		.word_t (pix9_t)
	) u_store (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	rotate_scanout u_scanout (
		.clk        (clk),
		.reset      (reset),
		.out_ce     (out_ce),
		.frame_bank (frame_bank),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.out_r      (out_r),
		.out_g      (out_g),
		.out_b      (out_b),
		.out_valid  (out_valid),
		.out_de     (out_de),
		.out_hblank (out_hblank),
		.out_vblank (out_vblank),
		.hsync      (hsync),
		.vsync      (vsync)
	);

endmodule

`default_nettype wire

// ==== verilog/rotate_geom_pkg.sv ====
//==================================================
// Rotation geometry
// Source frame size, store addressing and the
// portrait output timing of the scan-out
//==================================================
`default_nettype none

package rotate_geom_pkg;
	// Landscape source frame
	localparam int SRC_WIDTH    = 16;
	localparam int SRC_HEIGHT   = 8;
	localparam int FRAME_PIXELS = SRC_WIDTH * SRC_HEIGHT;

	// Two banks of one frame each
	localparam int ADDR_BITS = $clog2(2 * FRAME_PIXELS);
	typedef logic [ADDR_BITS-1:0] addr_t;

	// Portrait output, one source column per output line
	localparam int OUT_MARGIN = 4;
	localparam int OUT_LINES  = SRC_WIDTH + 2 * OUT_MARGIN;
	localparam int LINE_LEN   = SRC_HEIGHT + 18;
	localparam int HS_START   = SRC_HEIGHT + 8;
	localparam int HS_END     = SRC_HEIGHT + 10;
	localparam int VB_LINES   = 14;
	localparam int VS_START   = 10;
	localparam int VS_END     = 12;
endpackage

`default_nettype wire

// ==== verilog/rotate_scanout.sv ====
//==================================================
// Rotate scan-out
// Portrait output timing, frame store reads and
// colour expansion to 8 bits per channel
//==================================================
`default_nettype none

module rotate_scanout (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   out_ce,
	input  logic                   frame_bank,
	output rotate_geom_pkg::addr_t rd_addr,
	input  pixel_pkg::pix9_t       rd_data,
	output pixel_pkg::chan8_t      out_r,
	output pixel_pkg::chan8_t      out_g,
	output pixel_pkg::chan8_t      out_b,
	output logic                   out_valid,
	output logic                   out_de,
	output logic                   out_hblank,
	output logic                   out_vblank,
	output logic                   hsync,
	output logic                   vsync
);
	import rotate_geom_pkg::*;
	import pixel_pkg::*;

	logic [$clog2(LINE_LEN)-1:0]   col;
	logic [$clog2(OUT_LINES)-1:0]  line;
	logic [$clog2(VB_LINES+1)-1:0] vb_cnt;
	logic                          in_vb;
	logic                          running;
	logic                          shown_bank;
	logic                          pic_line;
	logic                          line_end;

	// Lines between the top and bottom margins carry picture
	assign pic_line = !in_vb && (line >= OUT_MARGIN) && (line < OUT_MARGIN + SRC_WIDTH);
	assign line_end = (col == LINE_LEN - 1);

	//==================================================
	// Output timing and read address
	//==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			col        <= '0;
			line       <= '0;
			vb_cnt     <= '0;
			in_vb      <= 1'b1;
			running    <= 1'b0;
			shown_bank <= 1'b0;
			rd_addr    <= '0;
			out_valid  <= 1'b0;
			out_de     <= 1'b0;
			out_hblank <= 1'b0;
			out_vblank <= 1'b0;
			hsync      <= 1'b0;
			vsync      <= 1'b0;
		end else begin
			out_valid <= out_ce && running;
			if (out_ce) begin
				// Levels of this step, seen one clock later
				out_de     <= running && pic_line && (col < SRC_HEIGHT);
				out_hblank <= running && (col >= SRC_HEIGHT);
				out_vblank <= running && in_vb;
				hsync      <= running && (col >= HS_START) && (col < HS_END);
				vsync      <= running && in_vb && (vb_cnt >= VS_START) && (vb_cnt < VS_END);

				// Point at the next pixel, the store answers next clock
				if (pic_line && (col < SRC_HEIGHT)) begin
					rd_addr <= rd_addr + 1'b1;
				end

				if (line_end) begin
					col <= '0;
					if (frame_bank != shown_bank) begin
						// New bank completed, restart on it
						shown_bank <= frame_bank;
						running    <= 1'b1;
						in_vb      <= 1'b0;
						line       <= '0;
						vb_cnt     <= '0;
						rd_addr    <= frame_bank ? addr_t'(FRAME_PIXELS) : addr_t'(0);
					end else if (in_vb) begin
						// Hold in blank until the next bank arrives
						if (vb_cnt < VB_LINES) begin
							vb_cnt <= vb_cnt + 1'b1;
						end
					end else if (line == OUT_LINES - 1) begin
						in_vb  <= 1'b1;
						vb_cnt <= '0;
					end else begin
						line <= line + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	//==================================================
	// Colour, black outside the picture
	//==================================================
	assign out_r = out_de ? expand3(pix_red(rd_data)) : '0;
	assign out_g = out_de ? expand3(pix_green(rd_data)) : '0;
	assign out_b = out_de ? expand3(pix_blue(rd_data)) : '0;

	// Every shown pixel was read from the bank on display
	a_read_in_bank: assert property (@(posedge clk) disable iff (reset)
		out_de |-> ($past(rd_addr) >= (shown_bank ? FRAME_PIXELS : 0))
			&& ($past(rd_addr) < (shown_bank ? 2 * FRAME_PIXELS : FRAME_PIXELS)));

endmodule

`default_nettype wire

// ==== verilog/rotate_writer.sv ====
//==================================================
// Rotate writer
// Captures enabled input pixels and stores them at
// rotated addresses in the bank being filled
//==================================================
`default_nettype none

module rotate_writer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   pix_ce,
	input  pixel_pkg::pix9_t       pix_in,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   rotate_ccw,
	output logic                   wr_en,
	output rotate_geom_pkg::addr_t wr_addr,
	output pixel_pkg::pix9_t       wr_data,
	output logic                   frame_bank
);
	import rotate_geom_pkg::*;

	// One spare bit so both counters can saturate past the frame
	logic [$clog2(SRC_WIDTH):0]  col;
	logic [$clog2(SRC_HEIGHT):0] row;
	logic                        blank;
	logic                        blank_d;
	logic                        vblank_d;
	logic                        blank_rise;
	logic                        vb_rise;
	logic                        ccw_q;
	logic                        active;
	logic                        in_frame;
	addr_t                       bank_base;
	addr_t                       pix_offset;

	assign blank      = hblank | vblank;
	assign blank_rise = blank & ~blank_d;
	assign vb_rise    = vblank & ~vblank_d;
	assign active     = pix_ce & ~blank;
	assign in_frame   = (col < SRC_WIDTH) && (row < SRC_HEIGHT);

	// Fill the bank opposite the one last completed
	assign bank_base = frame_bank ? addr_t'(0) : addr_t'(FRAME_PIXELS);

	//==================================================
	// Rotated address
	//==================================================
	always_comb begin
		if (ccw_q) begin
			pix_offset = addr_t'((SRC_WIDTH - 1 - col) * SRC_HEIGHT + row);
		end else begin
			pix_offset = addr_t'(col * SRC_HEIGHT + (SRC_HEIGHT - 1 - row));
		end
	end

	//==================================================
	// Frame counters and bank swap
	//==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			col        <= '0;
			row        <= '0;
			// Start as if in blanking, so a held vblank is no frame end
			blank_d    <= 1'b1;
			vblank_d   <= 1'b1;
			ccw_q      <= 1'b0;
			frame_bank <= 1'b0;
			wr_en      <= 1'b0;
		end else begin
			blank_d  <= blank;
			vblank_d <= vblank;
			wr_en    <= active && in_frame;
			if (vb_rise) begin
				col        <= '0;
				row        <= '0;
				ccw_q      <= rotate_ccw;
				frame_bank <= ~frame_bank;
			end else if (blank_rise) begin
				col <= '0;
				if (row < SRC_HEIGHT) begin
					row <= row + 1'b1;
				end
			end else if (active && (col < SRC_WIDTH)) begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wr_addr <= bank_base + pix_offset;
		wr_data <= pix_in;
	end

	// A write never reaches into the bank on display
	a_wr_in_bank: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> (wr_addr >= bank_base) && (wr_addr < bank_base + FRAME_PIXELS));

endmodule

`default_nettype wire
